//--- rtl/ring_reader_consts.svh
// Ring reader sizing constants
// Widths of data lines, addresses and ring indices, and the size of the
// reorder buffer that sorts out-of-order memory responses

`ifndef RING_READER_CONSTS_SVH
`define RING_READER_CONSTS_SVH

// One data line as it comes back from host memory
`define RR_LINE_BITS 64

// Line address width on the memory request channel
`define RR_ADDR_BITS 32

// Ring index width, so the ring holds 64 lines
// The ring size has to stay a power of two because indices wrap naturally
`define RR_RING_IDX_BITS 6

// Number of reorder slots, which also bounds the reads in flight
`define RR_ROB_ENTRIES 8

// Width of a reorder slot index and of a memory request tag
`define RR_ROB_IDX_BITS 3

`endif

//--- rtl/ring_reader_pkg.sv
// Ring reader shared types
// Data, address and index types used across the requester, the reorder
// buffer and the output stage, plus the reorder slot state

`include "ring_reader_consts.svh"

package ring_reader_pkg;

    // One line of ring buffer data
    typedef logic [`RR_LINE_BITS-1:0] line_t;

    // Line address in host memory
    typedef logic [`RR_ADDR_BITS-1:0] addr_t;

    // Ring slot index, wraps modulo the ring size
    typedef logic [`RR_RING_IDX_BITS-1:0] ring_idx_t;

    // Reorder slot index, sent with each read and returned with its response
    typedef logic [`RR_ROB_IDX_BITS-1:0] rob_tag_t;

    // Life cycle of one reorder slot
    // Free until allocated, waiting until its response lands, ready until taken
    typedef enum logic [1:0] {
        slot_free,
        slot_waiting,
        slot_ready
    } slot_state_t;

endpackage

//--- rtl/line_read_requester.sv
// Line read requester
// Walks the ring from the last requested slot toward the host write pointer
// and issues one tagged memory read per unread line while the reorder
// buffer still has a free slot

`timescale 1ns/1ps

module line_read_requester
    import ring_reader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Ring configuration and the host write pointer
    input  addr_t     base_addr,
    input  ring_idx_t newest_idx,

    // Slot allocation from the reorder buffer
    input  logic      rob_has_space,
    input  rob_tag_t  alloc_tag,
    output logic      alloc,

    // Tagged memory read request channel
    output logic      mem_req_valid,
    output addr_t     mem_req_addr,
    output rob_tag_t  mem_req_tag,
    input  logic      mem_req_ready
);

    // ==============================
    // Ring pointer
    // ==============================

    // Index of the next ring slot to request
    ring_idx_t next_idx;

    // High while the host has published lines that were not yet requested
    logic      has_unread;

    // The pointers are equal exactly when all published lines are requested
    // A full ring never looks empty here because the host stops short of
    // oldest_idx before it catches up
    assign has_unread = (next_idx != newest_idx);

    // ==============================
    // Request generation
    // ==============================

    // Ask for a line only when there is one to read and a slot to sort it in
    // The request is combinational so a new read can go out every cycle
    assign mem_req_valid = has_unread && rob_has_space;

    // The index is added to the base rather than replacing low address bits
    // That way the ring need not be aligned to its own size
    // Wrapping still relies on the ring size being a power of two
    assign mem_req_addr = base_addr + addr_t'(next_idx);

    // The tag names the reorder slot reserved for this read
    // It stays steady while valid is held because only a transfer moves it
    assign mem_req_tag = alloc_tag;

    // A slot is taken in the very cycle the read transfers
    assign alloc = mem_req_valid && mem_req_ready;

    // ==============================
    // Pointer update
    // ==============================

    // Step to the next ring slot on each accepted read
    // The pointer wraps from the last slot back to slot 0 on its own
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            next_idx <= '0;
        end
        else if (alloc)
        begin
            next_idx <= next_idx + 1'b1;
        end
    end

endmodule

//--- rtl/read_reorder_buffer.sv
// Read reorder buffer
// Hands out slot tags in request order, stores memory responses by tag as
// they arrive in any order, and releases the lines in request order

`timescale 1ns/1ps

`include "ring_reader_consts.svh"

module read_reorder_buffer
    import ring_reader_pkg::*;
(
    input  logic     clk,
    input  logic     reset,

    // Allocation side, driven by the requester
    input  logic     alloc,
    output rob_tag_t alloc_tag,
    output logic     rob_has_space,

    // Memory responses, accepted in the cycle they appear
    input  logic     rsp_valid,
    input  rob_tag_t rsp_tag,
    input  line_t    rsp_data,

    // In-order release toward the output stage
    output logic     head_valid,
    output line_t    head_data,
    input  logic     head_take
);

    // Occupancy needs one more bit than a slot index to count a full buffer
    localparam int COUNT_BITS = `RR_ROB_IDX_BITS + 1;

    // ==============================
    // Slot bookkeeping
    // ==============================

    // Next slot to allocate, in request order
    rob_tag_t tail_idx;

    // Oldest allocated slot, the next one to release
    rob_tag_t head_idx;

    // Slots that are waiting or ready
    logic [COUNT_BITS-1:0] used_count;

    // State of every slot
    slot_state_t slot_state [`RR_ROB_ENTRIES];

    // Response payload, one line per slot
    line_t slot_data [`RR_ROB_ENTRIES];

    // The next tag is always the tail, slots are handed out strictly in order
    assign alloc_tag = tail_idx;

    // Requests stop once every slot has a read in flight or a line parked
    assign rob_has_space = (used_count != COUNT_BITS'(`RR_ROB_ENTRIES));

    // The head line may leave only after its own response is in
    // Younger slots that are already ready must wait behind it
    assign head_valid = (slot_state[head_idx] == slot_ready);
    assign head_data  = slot_data[head_idx];

    // ==============================
    // Pointers and occupancy
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            tail_idx   <= '0;
            head_idx   <= '0;
            used_count <= '0;
        end
        else
        begin
            if (alloc)
            begin
                tail_idx <= tail_idx + 1'b1;
            end

            if (head_take)
            begin
                head_idx <= head_idx + 1'b1;
            end

            // An allocation and a release in one cycle leave the count alone
            if (alloc && !head_take)
            begin
                used_count <= used_count + 1'b1;
            end
            else if (!alloc && head_take)
            begin
                used_count <= used_count - 1'b1;
            end
        end
    end

    // ==============================
    // Slot state machine
    // ==============================

    // The three updates hit different slots in one cycle
    // Allocation takes a free slot, a response a waiting one, a take a ready one
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `RR_ROB_ENTRIES; i++)
            begin
                slot_state[i] <= slot_free;
            end
        end
        else
        begin
            if (alloc)
            begin
                slot_state[tail_idx] <= slot_waiting;
            end

            if (rsp_valid)
            begin
                slot_state[rsp_tag] <= slot_ready;
            end

            if (head_take)
            begin
                slot_state[head_idx] <= slot_free;
            end
        end
    end

    // Response data lands in the slot named by its tag
    always_ff @(posedge clk)
    begin
        if (rsp_valid)
        begin
            slot_data[rsp_tag] <= rsp_data;
        end
    end

endmodule

//--- rtl/line_stream_out.sv
// Line stream output stage
// A two-entry queue between the reorder buffer and the client stream, so
// client stalls never reach the buffer's head logic, plus the count of lines
// released that tells the host how far it may overwrite

`timescale 1ns/1ps

module line_stream_out
    import ring_reader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Head of the reorder buffer
    input  logic      head_valid,
    input  line_t     head_data,
    output logic      head_take,

    // Client stream
    output logic      out_valid,
    output line_t     out_data,
    input  logic      out_ready,

    // First ring slot the host may not overwrite yet
    output ring_idx_t oldest_idx
);

    // Queue storage and its pointers
    line_t      q_data [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] q_count;

    // Client handshake completes this cycle
    logic       out_pop;

    // Pull from the buffer whenever a line is there and the queue has room
    // A pop in the same cycle does not count, which keeps the path short
    assign head_take = head_valid && (q_count != 2'd2);

    assign out_valid = (q_count != 2'd0);
    assign out_data  = q_data[rd_ptr];
    assign out_pop   = out_valid && out_ready;

    // ==============================
    // Queue control
    // ==============================

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr  <= 1'b0;
            rd_ptr  <= 1'b0;
            q_count <= 2'd0;
        end
        else
        begin
            if (head_take)
                wr_ptr <= ~wr_ptr;
            if (out_pop)
                rd_ptr <= ~rd_ptr;

            // Push and pop together keep the fill level
            if (head_take && !out_pop)
                q_count <= q_count + 1'b1;
            else if (!head_take && out_pop)
                q_count <= q_count - 1'b1;
        end
    end

    // Taken lines are registered, so they show on the stream a cycle later
    always_ff @(posedge clk)
    begin
        if (head_take)
        begin
            q_data[wr_ptr] <= head_data;
        end
    end

    // ==============================
    // Oldest line pointer
    // ==============================

    // Counted as lines leave the buffer, which is far simpler than tracking
    // responses as they arrive out of order
    always_ff @(posedge clk)
    begin
        if (reset)
            oldest_idx <= '0;
        else if (head_take)
            oldest_idx <= oldest_idx + 1'b1;
    end

endmodule

//--- rtl/ring_reader_top.sv
// Ring reader top level
// Streams ring buffer lines from host memory to the FPGA client in order,
// built from the read requester, the reorder buffer and the output stage

`timescale 1ns/1ps

module ring_reader_top
    import ring_reader_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Ring configuration and host write pointer
    input  addr_t     base_addr,
    input  ring_idx_t newest_idx,

    // Tagged memory request channel
    output logic      mem_req_valid,
    output addr_t     mem_req_addr,
    output rob_tag_t  mem_req_tag,
    input  logic      mem_req_ready,

    // Memory response channel, no back-pressure
    input  logic      mem_rsp_valid,
    input  rob_tag_t  mem_rsp_tag,
    input  line_t     mem_rsp_data,

    // Client stream and consumer pointer for the host
    output logic      out_valid,
    output line_t     out_data,
    input  logic      out_ready,
    output ring_idx_t oldest_idx
);

    // Requester and reorder buffer handshake
    logic     alloc;
    rob_tag_t alloc_tag;
    logic     rob_has_space;

    // Reorder buffer head toward the output stage
    logic     head_valid;
    line_t    head_data;
    logic     head_take;

    line_read_requester u_requester (
        .clk           (clk),
        .reset         (reset),
        .base_addr     (base_addr),
        .newest_idx    (newest_idx),
        .rob_has_space (rob_has_space),
        .alloc_tag     (alloc_tag),
        .alloc         (alloc),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready)
    );

    read_reorder_buffer u_rob (
        .clk           (clk),
        .reset         (reset),
        .alloc         (alloc),
        .alloc_tag     (alloc_tag),
        .rob_has_space (rob_has_space),
        .rsp_valid     (mem_rsp_valid),
        .rsp_tag       (mem_rsp_tag),
        .rsp_data      (mem_rsp_data),
        .head_valid    (head_valid),
        .head_data     (head_data),
        .head_take     (head_take)
    );

    line_stream_out u_stream_out (
        .clk        (clk),
        .reset      (reset),
        .head_valid (head_valid),
        .head_data  (head_data),
        .head_take  (head_take),
        .out_valid  (out_valid),
        .out_data   (out_data),
        .out_ready  (out_ready),
        .oldest_idx (oldest_idx)
    );

endmodule

//--- verification/host_memory_model.sv
// Host memory model
// Accepts tagged line reads with a random ready pattern and answers each
// one after a random delay of 1 to 12 cycles, so responses come back out
// of order; each line holds the inverted address above the address itself

`timescale 1ns/1ps

`include "ring_reader_consts.svh"

module host_memory_model
    import ring_reader_pkg::*;
#(
    parameter logic [31:0] SEED = 32'd78
)
(
    input  logic     clk,
    input  logic     reset,

    // Read requests from the DUT
    input  logic     req_valid,
    input  addr_t    req_addr,
    input  rob_tag_t req_tag,
    output logic     req_ready,

    // Read responses back to the DUT
    output logic     rsp_valid,
    output rob_tag_t rsp_tag,
    output line_t    rsp_data,

    // Reads accepted but not yet answered, and tags that arrived twice
    output int       outstanding,
    output int       tag_clashes
);

    // Registered outputs start out idle before the first reset edge
    logic [31:0] rand_state    = SEED;
    logic        ready_q       = 1'b0;
    logic        rsp_valid_q   = 1'b0;
    rob_tag_t    rsp_tag_q     = '0;
    line_t       rsp_data_q    = '0;
    int          pending_count = 0;
    int          clash_count   = 0;

    // One pending read per tag, with its remaining delay and its line
    logic        pending     [`RR_ROB_ENTRIES];
    int          wait_cycles [`RR_ROB_ENTRIES];
    line_t       line_of     [`RR_ROB_ENTRIES];

    // Values worked out at each edge before the registers update
    logic [31:0] rnd;
    logic        accept;
    logic        pick_found;
    rob_tag_t    pick_tag;

    assign req_ready   = ready_q;
    assign rsp_valid   = rsp_valid_q;
    assign rsp_tag     = rsp_tag_q;
    assign rsp_data    = rsp_data_q;
    assign outstanding = pending_count;
    assign tag_clashes = clash_count;

    // Linear congruential generator step
    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // ==============================
    // Request intake and replies
    // ==============================

    always @(posedge clk)
    begin
        if (reset)
        begin
            rand_state    <= SEED;
            ready_q       <= 1'b0;
            rsp_valid_q   <= 1'b0;
            pending_count <= 0;
            clash_count   <= 0;
            for (int i = 0; i < `RR_ROB_ENTRIES; i++)
            begin
                pending[i]     <= 1'b0;
                wait_cycles[i] <= 0;
            end
        end
        else
        begin
            rnd    = next_random(rand_state);
            accept = req_valid && ready_q;

            // The lowest tag whose delay has run out answers this cycle
            pick_found = 1'b0;
            pick_tag   = '0;
            for (int i = `RR_ROB_ENTRIES - 1; i >= 0; i--)
            begin
                if (pending[i] && wait_cycles[i] == 0)
                begin
                    pick_found = 1'b1;
                    pick_tag   = rob_tag_t'(i);
                end
            end

            // Ready is high about three cycles out of four
            rand_state <= rnd;
            ready_q    <= (rnd[17:16] != 2'b00);

            for (int i = 0; i < `RR_ROB_ENTRIES; i++)
            begin
                if (pending[i] && wait_cycles[i] > 0)
                begin
                    wait_cycles[i] <= wait_cycles[i] - 1;
                end
            end

            if (accept)
            begin
                // A tag still in flight must never be sent again
                if (pending[req_tag])
                begin
                    clash_count <= clash_count + 1;
                end
                pending[req_tag]     <= 1'b1;
                wait_cycles[req_tag] <= 1 + int'(rnd[27:24]) % 12;
                line_of[req_tag]     <= {~req_addr, req_addr};
            end

            rsp_valid_q <= pick_found;
            rsp_tag_q   <= pick_tag;
            rsp_data_q  <= line_of[pick_tag];
            if (pick_found)
            begin
                pending[pick_tag] <= 1'b0;
            end

            pending_count <= pending_count + (accept ? 1 : 0) - (pick_found ? 1 : 0);
        end
    end

endmodule

//--- verification/ring_reader_tb.sv
// Ring reader testbench
// Publishes ring lines row by row from a stimulus table, lets the host
// memory model answer reads out of order, and checks that the client
// stream carries every line once and in ring order

`timescale 1ns/1ps

`include "ring_reader_consts.svh"

module ring_reader_tb
    import ring_reader_pkg::*;
();

    // Each row sets the ring base, the lines to publish and the client stall rate
    // Row 2 runs past index 63 from an unaligned base, row 3 wraps the address
    localparam int    ROWS = 4;
    localparam addr_t ROW_BASE  [ROWS] = '{32'h1000_0000, 32'h2000_0400,
                                           32'h3000_0013, 32'hffff_fff5};
    localparam int    ROW_LINES [ROWS] = '{20, 30, 40, 10};
    localparam int    ROW_STALL [ROWS] = '{0, 50, 25, 75};

    logic        clk;
    logic        reset;
    addr_t       base_addr;
    ring_idx_t   newest_idx;
    logic        out_ready = 1'b0;

    logic        mem_req_valid;
    addr_t       mem_req_addr;
    rob_tag_t    mem_req_tag;
    logic        mem_req_ready;
    logic        mem_rsp_valid;
    rob_tag_t    mem_rsp_tag;
    line_t       mem_rsp_data;
    logic        out_valid;
    line_t       out_data;
    ring_idx_t   oldest_idx;
    int          outstanding;
    int          tag_clashes;

    // Checker state, the ring index of the next expected line and its count
    logic [31:0] rand_state = 32'd78;
    logic [31:0] stall_pct;
    ring_idx_t   exp_idx     = '0;
    int          received    = 0;
    int          error_count = 0;
    int          target;
    int          cycle_count;
    int          cycle_limit;

    ring_reader_top UUT (
        .clk           (clk),
        .reset         (reset),
        .base_addr     (base_addr),
        .newest_idx    (newest_idx),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_tag   (mem_req_tag),
        .mem_req_ready (mem_req_ready),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_tag   (mem_rsp_tag),
        .mem_rsp_data  (mem_rsp_data),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .out_ready     (out_ready),
        .oldest_idx    (oldest_idx)
    );

    host_memory_model u_memory (
        .clk         (clk),
        .reset       (reset),
        .req_valid   (mem_req_valid),
        .req_addr    (mem_req_addr),
        .req_tag     (mem_req_tag),
        .req_ready   (mem_req_ready),
        .rsp_valid   (mem_rsp_valid),
        .rsp_tag     (mem_rsp_tag),
        .rsp_data    (mem_rsp_data),
        .outstanding (outstanding),
        .tag_clashes (tag_clashes)
    );

    // ==============================
    // Helpers
    // ==============================

    function automatic logic [31:0] next_random(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // Memory contents, inverted address in the upper half
    function automatic line_t line_rule(input addr_t addr);
        return {~addr, addr};
    endfunction

    function automatic int total_table_lines();
        int sum;
        sum = 0;
        for (int r = 0; r < ROWS; r++)
        begin
            sum = sum + ROW_LINES[r];
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        if (actual !== expected)
        begin
            $display("mismatch %s expected 0x%0h got 0x%0h", name, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    // ==============================
    // Clock, client stalls, timeout
    // ==============================

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #20 clk = ~clk;
        end
    end

    // Client drops ready at random, about stall_pct percent of the cycles
    always @(posedge clk)
    begin
        rand_state <= next_random(rand_state);
        out_ready  <= ({17'd0, rand_state[30:16]} % 32'd100) >= stall_pct;
    end

    // Forty cycles per line plus a margin for reset and the quiet checks
    initial
    begin
        cycle_limit = 40 * total_table_lines() + 2000;
        cycle_count = 0;
        while (cycle_count < cycle_limit)
        begin
            @(posedge clk);
            cycle_count = cycle_count + 1;
        end
        $display("error: run timed out after %0d cycles before all lines arrived",
                 cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    // ==============================
    // Output monitor
    // ==============================

    // At the falling edge the handshake of the next rising edge is already settled
    initial
    begin
        forever
        begin
            @(negedge clk);
            if (!reset)
            begin
                if (out_valid && out_ready)
                begin
                    check_value("out_data", 64'(line_rule(base_addr + addr_t'(exp_idx))),
                                64'(out_data));
                    exp_idx  = exp_idx + 1'b1;
                    received = received + 1;
                end
                if (outstanding > `RR_ROB_ENTRIES)
                begin
                    $display("error: %0d memory reads outstanding, more than %0d slots",
                             outstanding, `RR_ROB_ENTRIES);
                    error_count = error_count + 1;
                end
            end
        end
    end

    // ==============================
    // Stimulus
    // ==============================

    initial
    begin
        reset      = 1'b1;
        base_addr  = '0;
        newest_idx = '0;
        stall_pct  = '0;
        target     = 0;

        repeat (16) @(posedge clk);
        reset <= 1'b0;

        // Idle after reset, and no read while the ring looks empty
        @(negedge clk);
        check_value("out_valid", 64'd0, 64'(out_valid));
        check_value("oldest_idx", 64'd0, 64'(oldest_idx));
        repeat (4)
        begin
            @(negedge clk);
            check_value("mem_req_valid", 64'd0, 64'(mem_req_valid));
        end

        for (int row = 0; row < ROWS; row++)
        begin
            // The host publishes the whole row at once
            @(posedge clk);
            base_addr  <= ROW_BASE[row];
            newest_idx <= newest_idx + ring_idx_t'(ROW_LINES[row]);
            stall_pct  <= 32'(ROW_STALL[row]);
            target = target + ROW_LINES[row];

            while (received < target)
            begin
                @(posedge clk);
            end

            // Caught up, so the host may overwrite up to its own pointer
            @(negedge clk);
            check_value("oldest_idx", 64'(newest_idx), 64'(oldest_idx));
            repeat (3)
            begin
                @(negedge clk);
                check_value("mem_req_valid", 64'd0, 64'(mem_req_valid));
            end
        end

        @(negedge clk);
        check_value("outstanding", 64'd0, 64'(outstanding));
        check_value("tag_clashes", 64'd0, 64'(tag_clashes));
        $display("Finished %0d lines with %0d errors", received, error_count);
        if (error_count == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+rtl
rtl/ring_reader_pkg.sv
rtl/line_read_requester.sv
rtl/read_reorder_buffer.sv
rtl/line_stream_out.sv
rtl/ring_reader_top.sv
verification/host_memory_model.sv
verification/ring_reader_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the ring reader testbench with Verilator and runs it once

cd "$(dirname "$0")" || exit 1

verilator --binary -j 0 --top-module ring_reader_tb -f list.f -o ring_reader_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/ring_reader_sim)
sim_status=$?
echo "$sim_output"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_output" | grep -q "^TEST PASSED$"; then
    exit 0
fi
exit 1
